// ==== design/mips_id_pkg.sv ====
// widths, opcodes, function codes and decode enums for the decode stage; op codes match the usual EX encoding
package mips_id_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// primary opcodes, inst[31:26]
	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_ADDI    = 6'b001000;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_SLTIU   = 6'b001011;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;

	// function field of SPECIAL, inst[5:0]
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	typedef enum logic [7:0] {
		ALU_NOP   = 8'b0000_0000,
		ALU_SRL   = 8'b0000_0010,
		ALU_SRA   = 8'b0000_0011,
		ALU_MOVZ  = 8'b0000_1010,
		ALU_MOVN  = 8'b0000_1011,
		ALU_ADD   = 8'b0010_0000,
		ALU_ADDU  = 8'b0010_0001,
		ALU_SUB   = 8'b0010_0010,
		ALU_SUBU  = 8'b0010_0011,
		ALU_AND   = 8'b0010_0100,
		ALU_OR    = 8'b0010_0101,
		ALU_XOR   = 8'b0010_0110,
		ALU_NOR   = 8'b0010_0111,
		ALU_SLT   = 8'b0010_1010,
		ALU_SLTU  = 8'b0010_1011,
		ALU_ADDI  = 8'b0101_0101,
		ALU_ADDIU = 8'b0101_0110,
		ALU_SLTI  = 8'b0101_0111,
		ALU_SLTIU = 8'b0101_1000,
		ALU_SLL   = 8'b0111_1100
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP   = 3'd0,
		SEL_LOGIC = 3'd1,
		SEL_SHIFT = 3'd2,
		SEL_MOVE  = 3'd3,
		SEL_ARITH = 3'd4
	} alu_sel_e;

	// write-back rule, the conditional ones are resolved in the stage register
	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALWAYS,
		WB_IF_NONZERO,
		WB_IF_ZERO
	} wb_cond_e;

endpackage

// ==== design/dec_ctrl_if.sv ====
// decoded control of one instruction, plain levels valid in the same cycle as the instruction word
`timescale 1ns/1ps

interface dec_ctrl_if;
	import mips_id_pkg::*;

	alu_op_e   alu_op;
	alu_sel_e  alu_sel;
	wb_cond_e  wb_cond;
	reg_addr_t dest;     // destination register
	logic      rd1_en;
	logic      rd2_en;
	reg_addr_t rd1_addr; // always rs
	reg_addr_t rd2_addr; // always rt
	word_t     imm;

	modport decoder (
		output alu_op, alu_sel, wb_cond, dest,
		output rd1_en, rd2_en, rd1_addr, rd2_addr, imm
	);

	modport sink (
		input alu_op, alu_sel, wb_cond, dest,
		input rd1_en, rd2_en, rd1_addr, rd2_addr, imm
	);

endinterface

// ==== design/bypass_if.sv ====
// write-back buses of the EX and MEM stages for forwarding; register 0 gets no special handling here
`timescale 1ns/1ps

interface bypass_if;
	import mips_id_pkg::*;

	reg_addr_t ex_wd;
	logic      ex_wreg;
	word_t     ex_wdata;
	reg_addr_t mem_wd;
	logic      mem_wreg;
	word_t     mem_wdata;

	modport sink (
		input ex_wd, ex_wreg, ex_wdata,
		input mem_wd, mem_wreg, mem_wdata
	);

endinterface

// ==== design/inst_decoder.sv ====
// purely combinational decode; any word outside the kept subset gives an all-off nop with zero immediate
`timescale 1ns/1ps

module inst_decoder (
	input mips_id_pkg::word_t inst_i,
	dec_ctrl_if.decoder       ctrl
);
	import mips_id_pkg::*;

	logic [5:0]         opcode;
	reg_addr_t          rs;
	reg_addr_t          rt;
	reg_addr_t          rd;
	logic [SHAMT_W-1:0] shamt;
	logic [5:0]         funct;
	logic [15:0]        imm16;

	alu_op_e   op;
	alu_sel_e  sel;
	wb_cond_e  wb;
	reg_addr_t dest;
	logic      rd1_en;
	logic      rd2_en;
	word_t     imm;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	always_comb begin
		op     = ALU_NOP;
		sel    = SEL_NOP;
		wb     = WB_NONE;
		dest   = '0;
		rd1_en = 1'b0;
		rd2_en = 1'b0;
		imm    = '0;

		case (opcode)
			OPC_SPECIAL: begin
				case (funct)
					FN_AND:  begin op = ALU_AND;  sel = SEL_LOGIC; end
					FN_OR:   begin op = ALU_OR;   sel = SEL_LOGIC; end
					FN_XOR:  begin op = ALU_XOR;  sel = SEL_LOGIC; end
					FN_NOR:  begin op = ALU_NOR;  sel = SEL_LOGIC; end
					FN_SLLV: begin op = ALU_SLL;  sel = SEL_SHIFT; end
					FN_SRLV: begin op = ALU_SRL;  sel = SEL_SHIFT; end
					FN_SRAV: begin op = ALU_SRA;  sel = SEL_SHIFT; end
					FN_MOVN: begin op = ALU_MOVN; sel = SEL_MOVE;  end
					FN_MOVZ: begin op = ALU_MOVZ; sel = SEL_MOVE;  end
					FN_ADD:  begin op = ALU_ADD;  sel = SEL_ARITH; end
					FN_ADDU: begin op = ALU_ADDU; sel = SEL_ARITH; end
					FN_SUB:  begin op = ALU_SUB;  sel = SEL_ARITH; end
					FN_SUBU: begin op = ALU_SUBU; sel = SEL_ARITH; end
					FN_SLT:  begin op = ALU_SLT;  sel = SEL_ARITH; end
					FN_SLTU: begin op = ALU_SLTU; sel = SEL_ARITH; end
					// fixed shifts need inst[31:21] all zero, opcode is already zero here
					FN_SLL: begin
						if (rs == '0) begin
							op  = ALU_SLL;
							sel = SEL_SHIFT;
						end
					end
					FN_SRL: begin
						if (rs == '0) begin
							op  = ALU_SRL;
							sel = SEL_SHIFT;
						end
					end
					FN_SRA: begin
						if (rs == '0) begin
							op  = ALU_SRA;
							sel = SEL_SHIFT;
						end
					end
					default: ;
				endcase

				// every recognised R-type reads rs and rt and writes rd
				if (sel != SEL_NOP) begin
					dest   = rd;
					rd1_en = 1'b1;
					rd2_en = 1'b1;
					wb     = WB_ALWAYS;
					if (funct == FN_MOVN)
						wb = WB_IF_NONZERO;
					else if (funct == FN_MOVZ)
						wb = WB_IF_ZERO;
					if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
						rd1_en = 1'b0; // port 1 carries shamt instead
						imm    = {{(WORD_W-SHAMT_W){1'b0}}, shamt};
					end
				end
			end
			OPC_ANDI: begin
				op  = ALU_AND;
				sel = SEL_LOGIC;
				imm = {{(WORD_W-16){1'b0}}, imm16};
			end
			OPC_ORI: begin
				op  = ALU_OR;
				sel = SEL_LOGIC;
				imm = {{(WORD_W-16){1'b0}}, imm16};
			end
			OPC_XORI: begin
				op  = ALU_XOR;
				sel = SEL_LOGIC;
				imm = {{(WORD_W-16){1'b0}}, imm16};
			end
			OPC_LUI: begin
				op  = ALU_OR; // rs | (imm << 16)
				sel = SEL_LOGIC;
				imm = {imm16, {(WORD_W-16){1'b0}}};
			end
			OPC_ADDI:  begin op = ALU_ADDI;  sel = SEL_ARITH; end
			OPC_ADDIU: begin op = ALU_ADDIU; sel = SEL_ARITH; end
			OPC_SLTI:  begin op = ALU_SLTI;  sel = SEL_ARITH; end
			OPC_SLTIU: begin op = ALU_SLTIU; sel = SEL_ARITH; end
			default: ;
		endcase

		// I-type: rs on port 1, immediate on port 2, result to rt
		if (opcode != OPC_SPECIAL && sel != SEL_NOP) begin
			dest   = rt;
			rd1_en = 1'b1;
			wb     = WB_ALWAYS;
			if (sel == SEL_ARITH)
				imm = {{(WORD_W-16){imm16[15]}}, imm16}; // sign extended
		end
	end

	assign ctrl.alu_op   = op;
	assign ctrl.alu_sel  = sel;
	assign ctrl.wb_cond  = wb;
	assign ctrl.dest     = dest;
	assign ctrl.rd1_en   = rd1_en;
	assign ctrl.rd2_en   = rd2_en;
	assign ctrl.rd1_addr = rs;
	assign ctrl.rd2_addr = rt;
	assign ctrl.imm      = imm;

endmodule

// ==== design/operand_mux.sv ====
// one source operand with EX over MEM over register file priority; a disabled read returns the immediate
`timescale 1ns/1ps

module operand_mux (
	input  logic                   rd_en_i,
	input  mips_id_pkg::reg_addr_t rd_addr_i,
	input  mips_id_pkg::word_t     rf_data_i,
	input  mips_id_pkg::word_t     imm_i,
	bypass_if.sink                 byp,
	output mips_id_pkg::word_t     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// no r0 exclusion, the register file keeps r0 at zero
	assign ex_hit  = byp.ex_wreg && (byp.ex_wd == rd_addr_i);
	assign mem_hit = byp.mem_wreg && (byp.mem_wd == rd_addr_i);

	always_comb begin
		if (!rd_en_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = byp.ex_wdata; // youngest result wins
		else if (mem_hit)
			operand_o = byp.mem_wdata;
		else
			operand_o = rf_data_i;
	end

endmodule

// ==== design/id_ex_reg.sv ====
// ID/EX register with async clear; movn/movz write enable is decided from the forwarded rt value
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                   clk,
	input  logic                   arst_n_i,
	dec_ctrl_if.sink               ctrl,
	input  mips_id_pkg::word_t     op1_i,
	input  mips_id_pkg::word_t     op2_i,
	output mips_id_pkg::alu_op_e   aluop_o,
	output mips_id_pkg::alu_sel_e  alusel_o,
	output mips_id_pkg::reg_addr_t wd_o,
	output logic                   wreg_o,
	output mips_id_pkg::word_t     reg1_o,
	output mips_id_pkg::word_t     reg2_o
);
	import mips_id_pkg::*;

	logic wreg_d;

	always_comb begin
		case (ctrl.wb_cond)
			WB_ALWAYS:     wreg_d = 1'b1;
			WB_IF_NONZERO: wreg_d = (op2_i != '0); // movn
			WB_IF_ZERO:    wreg_d = (op2_i == '0); // movz
			default:       wreg_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			aluop_o  <= ALU_NOP;
			alusel_o <= SEL_NOP;
			wd_o     <= '0;
			wreg_o   <= 1'b0;
			reg1_o   <= '0;
			reg2_o   <= '0;
		end else begin
			aluop_o  <= ctrl.alu_op;
			alusel_o <= ctrl.alu_sel;
			wd_o     <= ctrl.dest;
			wreg_o   <= wreg_d;
			reg1_o   <= op1_i;
			reg2_o   <= op2_i;
		end
	end

endmodule

// ==== design/id_stage.sv ====
// decode stage top; register-file reads are combinational from inst_i, everything else has one cycle latency
`timescale 1ns/1ps

module id_stage (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  mips_id_pkg::word_t     inst_i,
	input  mips_id_pkg::word_t     reg1_data_i,
	input  mips_id_pkg::word_t     reg2_data_i,
	input  mips_id_pkg::reg_addr_t ex_wd_i,
	input  logic                   ex_wreg_i,
	input  mips_id_pkg::word_t     ex_wdata_i,
	input  mips_id_pkg::reg_addr_t mem_wd_i,
	input  logic                   mem_wreg_i,
	input  mips_id_pkg::word_t     mem_wdata_i,
	output mips_id_pkg::reg_addr_t reg1_addr_o,
	output logic                   reg1_read_o,
	output mips_id_pkg::reg_addr_t reg2_addr_o,
	output logic                   reg2_read_o,
	output mips_id_pkg::alu_op_e   aluop_o,
	output mips_id_pkg::alu_sel_e  alusel_o,
	output mips_id_pkg::reg_addr_t wd_o,
	output logic                   wreg_o,
	output mips_id_pkg::word_t     reg1_o,
	output mips_id_pkg::word_t     reg2_o
);

	mips_id_pkg::word_t op1;
	mips_id_pkg::word_t op2;

	dec_ctrl_if ctrl_if ();
	bypass_if   byp_if ();

	assign byp_if.ex_wd     = ex_wd_i;
	assign byp_if.ex_wreg   = ex_wreg_i;
	assign byp_if.ex_wdata  = ex_wdata_i;
	assign byp_if.mem_wd    = mem_wd_i;
	assign byp_if.mem_wreg  = mem_wreg_i;
	assign byp_if.mem_wdata = mem_wdata_i;

	// register file read requests
	assign reg1_addr_o = ctrl_if.rd1_addr;
	assign reg1_read_o = ctrl_if.rd1_en;
	assign reg2_addr_o = ctrl_if.rd2_addr;
	assign reg2_read_o = ctrl_if.rd2_en;

	inst_decoder u_dec (
		.inst_i (inst_i),
		.ctrl   (ctrl_if.decoder)
	);

	operand_mux u_op1 (
		.rd_en_i   (ctrl_if.rd1_en),
		.rd_addr_i (ctrl_if.rd1_addr),
		.rf_data_i (reg1_data_i),
		.imm_i     (ctrl_if.imm),
		.byp       (byp_if.sink),
		.operand_o (op1)
	);

	operand_mux u_op2 (
		.rd_en_i   (ctrl_if.rd2_en),
		.rd_addr_i (ctrl_if.rd2_addr),
		.rf_data_i (reg2_data_i),
		.imm_i     (ctrl_if.imm),
		.byp       (byp_if.sink),
		.operand_o (op2)
	);

	id_ex_reg u_idex (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.ctrl     (ctrl_if.sink),
		.op1_i    (op1),
		.op2_i    (op2),
		.aluop_o  (aluop_o),
		.alusel_o (alusel_o),
		.wd_o     (wd_o),
		.wreg_o   (wreg_o),
		.reg1_o   (reg1_o),
		.reg2_o   (reg2_o)
	);

endmodule

// ==== test/tb_clk_gen.sv ====
// 4 ns clock; reset falls 1 ns in and is released 1 ns after the eighth rising edge
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b1;
		#1 arst_n_o = 1'b0; // a real falling edge for the async clear
		repeat (8) @(posedge clk_o);
		#1 arst_n_o = 1'b1;
	end

endmodule

// ==== test/id_stage_checker.sv ====
// concurrent checks on the registered class and write enable, sampled on every rising clk edge
`timescale 1ns/1ps

module id_stage_checker (
	input logic       clk_i,
	input logic       arst_n_i,
	input logic       wreg_i,
	input logic [2:0] alusel_i
);
	import mips_id_pkg::*;

	int fail_cnt = 0; // failed assertions so far

	// stage register is held clear while reset is low
	reset_clear: assert property (@(posedge clk_i)
		!arst_n_i |-> (!wreg_i && alusel_i == SEL_NOP))
		else begin
			$error("wreg or alusel not cleared during reset");
			fail_cnt++;
		end

	legal_class: assert property (@(posedge clk_i)
		alusel_i inside {SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_MOVE, SEL_ARITH})
		else begin
			$error("alusel holds a value outside the class encoding");
			fail_cnt++;
		end

	nop_no_write: assert property (@(posedge clk_i)
		(alusel_i == SEL_NOP) |-> !wreg_i)
		else begin
			$error("write enable set for a nop");
			fail_cnt++;
		end

endmodule

// ==== test/tb_id_stage.sv ====
// directed decode tests; register model is random from a fixed seed, EX/MEM buses idle unless driven
`timescale 1ns/1ps

module tb_id_stage;
	import mips_id_pkg::*;

	logic      clk;
	logic      arst_n;
	word_t     inst;
	word_t     reg1_data;
	word_t     reg2_data;
	reg_addr_t ex_wd;
	logic      ex_wreg;
	word_t     ex_wdata;
	reg_addr_t mem_wd;
	logic      mem_wreg;
	word_t     mem_wdata;
	reg_addr_t reg1_addr;
	logic      reg1_read;
	reg_addr_t reg2_addr;
	logic      reg2_read;
	alu_op_e   aluop;
	alu_sel_e  alusel;
	reg_addr_t wd;
	logic      wreg;
	word_t     reg1;
	word_t     reg2;

	word_t  regs [32]; // register file model
	integer seed;
	int     test_err;
	int     err_cnt;
	int     tests_run;
	int     tests_bad;
	logic   released;

	tb_clk_gen u_clk (.clk_o(clk), .arst_n_o(arst_n));

	id_stage dut (
		.clk(clk), .arst_n_i(arst_n), .inst_i(inst),
		.reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
		.ex_wd_i(ex_wd), .ex_wreg_i(ex_wreg), .ex_wdata_i(ex_wdata),
		.mem_wd_i(mem_wd), .mem_wreg_i(mem_wreg), .mem_wdata_i(mem_wdata),
		.reg1_addr_o(reg1_addr), .reg1_read_o(reg1_read),
		.reg2_addr_o(reg2_addr), .reg2_read_o(reg2_read),
		.aluop_o(aluop), .alusel_o(alusel), .wd_o(wd), .wreg_o(wreg),
		.reg1_o(reg1), .reg2_o(reg2)
	);

	bind id_stage id_stage_checker u_chk (
		.clk_i(clk), .arst_n_i(arst_n_i), .wreg_i(wreg_o), .alusel_i(alusel_o)
	);

	assign reg1_data = regs[inst[25:21]]; // rs field
	assign reg2_data = regs[inst[20:16]]; // rt field

	function automatic word_t r_word(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [4:0] sa, input logic [5:0] fn);
		return {OPC_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t i_word(input logic [5:0] opc, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	task automatic check_val(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic set_bypass(input logic ex_we, input reg_addr_t ex_a, input word_t ex_d,
		input logic mem_we, input reg_addr_t mem_a, input word_t mem_d);
		ex_wreg   = ex_we;
		ex_wd     = ex_a;
		ex_wdata  = ex_d;
		mem_wreg  = mem_we;
		mem_wd    = mem_a;
		mem_wdata = mem_d;
	endtask

	// called 1 ns after an edge; reads are checked at once, the result one edge later
	task automatic issue(input word_t word, input logic r1_en, input logic r2_en,
		input alu_op_e op, input alu_sel_e sel, input reg_addr_t dest, input logic we,
		input word_t op1, input word_t op2);
		inst = word;
		#1;
		check_val("reg1_addr_o", reg1_addr, word[25:21]);
		check_val("reg2_addr_o", reg2_addr, word[20:16]);
		check_val("reg1_read_o", reg1_read, r1_en);
		check_val("reg2_read_o", reg2_read, r2_en);
		@(posedge clk);
		#1;
		check_val("aluop_o", aluop, op);
		check_val("alusel_o", alusel, sel);
		check_val("wd_o", wd, dest);
		check_val("wreg_o", wreg, we);
		check_val("reg1_o", reg1, op1);
		check_val("reg2_o", reg2, op2);
	endtask

	task automatic check_cleared();
		check_val("aluop_o", aluop, ALU_NOP);
		check_val("alusel_o", alusel, SEL_NOP);
		check_val("wd_o", wd, '0);
		check_val("wreg_o", wreg, 1'b0);
		check_val("reg1_o", reg1, '0);
		check_val("reg2_o", reg2, '0);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_err == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_err);
			tests_bad++;
			err_cnt += test_err;
		end
		test_err = 0;
	endtask

	task automatic test_reset(output logic ok);
		int waited;
		waited = 0;
		repeat (2) @(posedge clk);
		#1;
		check_cleared(); // still inside reset
		while (arst_n !== 1'b1 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		ok = (arst_n === 1'b1);
		#1;
		check_cleared(); // first edge out of reset with an undecoded word
		end_test("reset");
	endtask

	task automatic test_logic();
		issue(r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_AND), 1, 1, ALU_AND, SEL_LOGIC, 5'd3, 1,
			regs[1], regs[2]);
		issue(r_word(5'd4, 5'd5, 5'd6, 5'd0, FN_OR), 1, 1, ALU_OR, SEL_LOGIC, 5'd6, 1,
			regs[4], regs[5]);
		issue(r_word(5'd7, 5'd8, 5'd9, 5'd0, FN_XOR), 1, 1, ALU_XOR, SEL_LOGIC, 5'd9, 1,
			regs[7], regs[8]);
		issue(r_word(5'd10, 5'd11, 5'd12, 5'd0, FN_NOR), 1, 1, ALU_NOR, SEL_LOGIC, 5'd12, 1,
			regs[10], regs[11]);
		issue(i_word(OPC_ANDI, 5'd13, 5'd14, 16'h8421), 1, 0, ALU_AND, SEL_LOGIC, 5'd14, 1,
			regs[13], 32'h0000_8421);
		issue(i_word(OPC_ORI, 5'd15, 5'd16, 16'hf0f0), 1, 0, ALU_OR, SEL_LOGIC, 5'd16, 1,
			regs[15], 32'h0000_f0f0);
		issue(i_word(OPC_XORI, 5'd18, 5'd19, 16'hffff), 1, 0, ALU_XOR, SEL_LOGIC, 5'd19, 1,
			regs[18], 32'h0000_ffff);
		issue(i_word(OPC_LUI, 5'd0, 5'd17, 16'hbeef), 1, 0, ALU_OR, SEL_LOGIC, 5'd17, 1,
			regs[0], 32'hbeef_0000);
		end_test("logic");
	endtask

	task automatic test_shifts();
		issue(r_word(5'd0, 5'd3, 5'd4, 5'd7, FN_SLL), 0, 1, ALU_SLL, SEL_SHIFT, 5'd4, 1,
			32'd7, regs[3]);
		issue(r_word(5'd0, 5'd5, 5'd6, 5'd31, FN_SRL), 0, 1, ALU_SRL, SEL_SHIFT, 5'd6, 1,
			32'd31, regs[5]);
		issue(r_word(5'd0, 5'd8, 5'd9, 5'd1, FN_SRA), 0, 1, ALU_SRA, SEL_SHIFT, 5'd9, 1,
			32'd1, regs[8]);
		issue(r_word(5'd10, 5'd11, 5'd12, 5'd0, FN_SLLV), 1, 1, ALU_SLL, SEL_SHIFT, 5'd12, 1,
			regs[10], regs[11]);
		issue(r_word(5'd13, 5'd14, 5'd15, 5'd0, FN_SRLV), 1, 1, ALU_SRL, SEL_SHIFT, 5'd15, 1,
			regs[13], regs[14]);
		issue(r_word(5'd16, 5'd17, 5'd18, 5'd0, FN_SRAV), 1, 1, ALU_SRA, SEL_SHIFT, 5'd18, 1,
			regs[16], regs[17]);
		// fixed shift with rs set is not a legal encoding
		issue(r_word(5'd2, 5'd3, 5'd4, 5'd7, FN_SLL), 0, 0, ALU_NOP, SEL_NOP, 5'd0, 0, 0, 0);
		end_test("shifts");
	endtask

	task automatic test_arith();
		logic [5:0] fns [6];
		alu_op_e    ops [6];
		fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
		ops = '{ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU};
		for (int i = 0; i < 6; i++)
			issue(r_word(reg_addr_t'(i + 1), reg_addr_t'(i + 9), reg_addr_t'(i + 20), 5'd0,
				fns[i]), 1, 1, ops[i], SEL_ARITH, reg_addr_t'(i + 20), 1, regs[i + 1],
				regs[i + 9]);
		issue(i_word(OPC_ADDI, 5'd1, 5'd2, 16'h8000), 1, 0, ALU_ADDI, SEL_ARITH, 5'd2, 1,
			regs[1], 32'hffff_8000);
		issue(i_word(OPC_ADDIU, 5'd3, 5'd4, 16'h7fff), 1, 0, ALU_ADDIU, SEL_ARITH, 5'd4, 1,
			regs[3], 32'h0000_7fff);
		issue(i_word(OPC_SLTI, 5'd5, 5'd6, 16'hfffe), 1, 0, ALU_SLTI, SEL_ARITH, 5'd6, 1,
			regs[5], 32'hffff_fffe);
		issue(i_word(OPC_SLTIU, 5'd7, 5'd8, 16'h0001), 1, 0, ALU_SLTIU, SEL_ARITH, 5'd8, 1,
			regs[7], 32'h0000_0001);
		end_test("arith");
	endtask

	task automatic test_forwarding();
		word_t add_w;
		add_w = r_word(5'd5, 5'd6, 5'd7, 5'd0, FN_ADD);
		set_bypass(1, 5'd5, 32'h1111_1111, 1, 5'd5, 32'h2222_2222); // EX over MEM
		issue(add_w, 1, 1, ALU_ADD, SEL_ARITH, 5'd7, 1, 32'h1111_1111, regs[6]);
		set_bypass(0, 5'd5, 32'h1111_1111, 1, 5'd5, 32'h2222_2222);
		issue(add_w, 1, 1, ALU_ADD, SEL_ARITH, 5'd7, 1, 32'h2222_2222, regs[6]);
		set_bypass(0, 5'd5, 32'h1111_1111, 0, 5'd5, 32'h2222_2222);
		issue(add_w, 1, 1, ALU_ADD, SEL_ARITH, 5'd7, 1, regs[5], regs[6]);
		set_bypass(1, 5'd6, 32'h3333_3333, 1, 5'd6, 32'h4444_4444); // port 2
		issue(add_w, 1, 1, ALU_ADD, SEL_ARITH, 5'd7, 1, regs[5], 32'h3333_3333);
		set_bypass(0, 5'd6, 32'h3333_3333, 1, 5'd6, 32'h4444_4444);
		issue(add_w, 1, 1, ALU_ADD, SEL_ARITH, 5'd7, 1, regs[5], 32'h4444_4444);
		set_bypass(0, 5'd6, 32'h3333_3333, 0, 5'd6, 32'h4444_4444);
		issue(add_w, 1, 1, ALU_ADD, SEL_ARITH, 5'd7, 1, regs[5], regs[6]);
		set_bypass(1, 5'd6, 32'h3333_3333, 1, 5'd6, 32'h4444_4444);
		issue(i_word(OPC_ADDI, 5'd5, 5'd6, 16'h0010), 1, 0, ALU_ADDI, SEL_ARITH, 5'd6, 1,
			regs[5], 32'h0000_0010);
		set_bypass(1, 5'd0, 32'h5555_5555, 1, 5'd0, 32'h6666_6666); // shamt wins on port 1
		issue(r_word(5'd0, 5'd6, 5'd7, 5'd3, FN_SLL), 0, 1, ALU_SLL, SEL_SHIFT, 5'd7, 1,
			32'd3, regs[6]);
		set_bypass(0, 5'd0, '0, 0, 5'd0, '0);
		end_test("forwarding");
	endtask

	task automatic test_moves_unknown();
		set_bypass(1, 5'd2, 32'h0000_0005, 0, 5'd0, '0);
		issue(r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_MOVN), 1, 1, ALU_MOVN, SEL_MOVE, 5'd3, 1,
			regs[1], 32'h0000_0005);
		issue(r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_MOVZ), 1, 1, ALU_MOVZ, SEL_MOVE, 5'd3, 0,
			regs[1], 32'h0000_0005);
		set_bypass(1, 5'd2, 32'h0000_0000, 0, 5'd0, '0);
		issue(r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_MOVN), 1, 1, ALU_MOVN, SEL_MOVE, 5'd3, 0,
			regs[1], 32'h0);
		issue(r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_MOVZ), 1, 1, ALU_MOVZ, SEL_MOVE, 5'd3, 1,
			regs[1], 32'h0);
		set_bypass(0, 5'd0, '0, 0, 5'd0, '0);
		issue(32'hfc00_0000, 0, 0, ALU_NOP, SEL_NOP, 5'd0, 0, 0, 0);
		issue(i_word(6'h23, 5'd1, 5'd2, 16'h1234), 0, 0, ALU_NOP, SEL_NOP, 5'd0, 0, 0, 0);
		end_test("moves_unknown");
	endtask

	initial begin
		seed = 84542;
		for (int i = 0; i < 32; i++)
			regs[i] = $random(seed);
		regs[0] = '0;
		inst = 32'hfc00_0000; // opcode 6'h3f, not decoded
		set_bypass(0, 5'd0, '0, 0, 5'd0, '0);
		test_err  = 0;
		err_cnt   = 0;
		tests_run = 0;
		tests_bad = 0;
		test_reset(released);
		if (!released) begin
			$display("timeout: reset was never released");
			$display("tests failed");
			$finish;
		end else begin
			test_logic();
			test_shifts();
			test_arith();
			test_forwarding();
			test_moves_unknown();
			$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
				tests_run, tests_bad, err_cnt, dut.u_chk.fail_cnt);
			if (tests_bad == 0 && dut.u_chk.fail_cnt == 0)
				$display("all tests passed");
			else
				$display("tests failed");
			$finish;
		end
	end

endmodule

// ==== mips_id.f ====
design/mips_id_pkg.sv
design/dec_ctrl_if.sv
design/bypass_if.sv
design/inst_decoder.sv
design/operand_mux.sv
design/id_ex_reg.sv
design/id_stage.sv
test/tb_clk_gen.sv
test/id_stage_checker.sv
test/tb_id_stage.sv
